/* vicii_pkg.sv */
package vicii_pkg;

  // supported chip models
  // only the line and frame geometry differs between them
  typedef enum logic {
    CHIP_6567R8 = 1'b0,
    CHIP_6569   = 1'b1
  } chip_t;

  // cycle within a raster line, 0..64 at most
  typedef logic [6:0] xcycle_t;

  // raster line number, 0..311 at most
  typedef logic [8:0] raster_t;

  // sprite registers and per-sprite masks
  typedef logic [7:0] sprite_y_t;
  typedef logic [7:0] sprite_mask_t;
  typedef logic [2:0] sprite_idx_t;

  // cpu side register port
  typedef logic [5:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;

  localparam int NUM_SPRITES = 8;

  // lines fetched per sprite once its Y matches
  localparam int SPRITE_HEIGHT = 21;

  // cycle of the line where the sprite Y compare is done
  localparam int SPRITE_CHECK_CYCLE = 55;

  // pixels per cpu cycle; each pixel is 4 clk_dot4x periods
  localparam int DOTS_PER_CYCLE = 8;

  // sprite enable register, decimal 21
  localparam reg_addr_t REG_SPRITE_EN = 6'h15;

endpackage : vicii_pkg

/* vic_clockgen.sv */
`timescale 1ns/1ps

module vic_clockgen
  import vicii_pkg::*;
#(
  parameter int RESET_HOLD = 16
) (
  input  logic clk_dot4x,
  input  logic rst,
  output logic sys_rst,
  output logic dot_ce,
  output logic cycle_ce,
  output logic phi0
);

  // wide enough to hold RESET_HOLD, never zero bits
  localparam int HOLD_W = $clog2(RESET_HOLD + 2);

  // last phase of one cpu cycle, 4 clocks per dot
  localparam int PHASE_LAST = 4 * DOTS_PER_CYCLE - 1;

  logic [HOLD_W-1:0] hold_cnt;
  logic [4:0]        phase;

  // reset stretcher
  // sys_rst follows rst up at once and drops RESET_HOLD clocks after rst falls
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      hold_cnt <= '0;
      sys_rst  <= 1'b1;
    end else if (hold_cnt != HOLD_W'(RESET_HOLD)) begin
      hold_cnt <= hold_cnt + 1'b1;
      sys_rst  <= 1'b1;
    end else begin
      sys_rst  <= 1'b0;
    end
  end

  // phase within the 32 clock cpu cycle
  // also cleared by rst so the strobes stop on the edge where sys_rst rises
  always_ff @(posedge clk_dot4x) begin
    if (rst || sys_rst) begin
      phase <= '0;
    end else if (phase == 5'(PHASE_LAST)) begin
      phase <= '0;
    end else begin
      phase <= phase + 5'd1;
    end
  end

  // one dot every 4 clocks
  assign dot_ce = (phase[1:0] == 2'b11);

  // last clock of the cycle, lines up with every 8th dot_ce
  assign cycle_ce = (phase == 5'(PHASE_LAST));

  // low half then high half, first phase right after cycle_ce
  assign phi0 = phase[4];

  // strobes stay quiet for the whole stretched reset
  a_no_strobe_in_reset : assert property (
    @(posedge clk_dot4x) sys_rst |-> !dot_ce && !cycle_ce
  );

endmodule : vic_clockgen

/* raster_counter.sv */
`timescale 1ns/1ps

module raster_counter
  import vicii_pkg::*;
#(
  parameter chip_t CHIP = CHIP_6567R8
) (
  input  logic    clk_dot4x,
  input  logic    sys_rst,
  input  logic    cycle_ce,
  output xcycle_t xcycle,
  output raster_t raster_line,
  output logic    check_ce
);

  // 65 cycles x 263 lines for ntsc, 63 x 312 for pal
  localparam xcycle_t LAST_CYCLE = (CHIP == CHIP_6569) ? 7'd62 : 7'd64;
  localparam raster_t LAST_LINE  = (CHIP == CHIP_6569) ? 9'd311 : 9'd262;

  // cycle just before the sprite compare cycle
  localparam xcycle_t CHECK_PREV = xcycle_t'(SPRITE_CHECK_CYCLE - 1);

  logic line_end;
  logic frame_end;

  // last cycle of the line is being left
  assign line_end = cycle_ce && (xcycle == LAST_CYCLE);

  // same, on the last line of the frame
  assign frame_end = line_end && (raster_line == LAST_LINE);

  // cycle within line
  always_ff @(posedge clk_dot4x) begin
    if (sys_rst) begin
      xcycle <= '0;
    end else if (line_end) begin
      xcycle <= '0;
    end else if (cycle_ce) begin
      xcycle <= xcycle + 7'd1;
    end
  end

  // raster line, steps as the cycle counter wraps
  always_ff @(posedge clk_dot4x) begin
    if (sys_rst) begin
      raster_line <= '0;
    end else if (frame_end) begin
      raster_line <= '0;
    end else if (line_end) begin
      raster_line <= raster_line + 9'd1;
    end
  end

  // fires on the cycle_ce that moves xcycle onto the compare cycle
  // the match units sample the new raster_line along with it
  assign check_ce = cycle_ce && (xcycle == CHECK_PREV);

  // counter wraps at the chip's last cycle
  a_xcycle_range : assert property (
    @(posedge clk_dot4x) !sys_rst |-> xcycle <= LAST_CYCLE
  );

endmodule : raster_counter

/* sprite_regs.sv */
`timescale 1ns/1ps

module sprite_regs
  import vicii_pkg::*;
(
  input  logic                       clk_dot4x,
  input  logic                       sys_rst,
  input  logic                       reg_we,
  input  reg_addr_t                  reg_addr,
  input  reg_data_t                  reg_wdata,
  output logic [NUM_SPRITES*8-1:0]   sprite_y_flat,
  output sprite_mask_t               sprite_en
);

  // one select per sprite Y register
  sprite_mask_t y_sel;
  logic         en_sel;

  // address decode
  // sprite n Y sits at 2n+1, the X registers in between are not modelled
  always_comb begin
    y_sel = '0;
    for (int n = 0; n < NUM_SPRITES; n++) begin
      if (reg_addr == reg_addr_t'(2 * n + 1)) begin
        y_sel[n] = reg_we;
      end
    end
  end

  // enable mask register
  assign en_sel = reg_we && (reg_addr == REG_SPRITE_EN);

  // register storage
  // sprite 0 Y in the low byte of the flat bus
  always_ff @(posedge clk_dot4x) begin
    if (sys_rst) begin
      sprite_y_flat <= '0;
      sprite_en     <= '0;
    end else begin
      for (int n = 0; n < NUM_SPRITES; n++) begin
        if (y_sel[n]) begin
          sprite_y_flat[n*8 +: 8] <= reg_wdata;
        end
      end
      // all other addresses fall through untouched
      if (en_sel) begin
        sprite_en <= reg_wdata;
      end
    end
  end

endmodule : sprite_regs

/* sprite_y_match.sv */
`timescale 1ns/1ps

module sprite_y_match
  import vicii_pkg::*;
(
  input  logic      clk_dot4x,
  input  logic      sys_rst,
  input  logic      check_ce,
  input  sprite_y_t raster_low,
  input  sprite_y_t sprite_y,
  input  logic      enable,
  output logic      dma_req
);

  localparam logic [4:0] HEIGHT = 5'(SPRITE_HEIGHT);

  typedef enum logic {
    IDLE,
    FETCH
  } state_t;

  state_t     state;
  logic [4:0] line_cnt;

  // compare once per line, at the check cycle
  // the match line itself is the first fetched line
  always_ff @(posedge clk_dot4x) begin
    if (sys_rst) begin
      state    <= IDLE;
      line_cnt <= '0;
    end else if (check_ce) begin
      case (state)
        IDLE: begin
          if (enable && (sprite_y == raster_low)) begin
            state    <= FETCH;
            line_cnt <= 5'd1;
          end
        end
        FETCH: begin
          // all lines done, release on this check
          if (line_cnt == HEIGHT) begin
            state    <= IDLE;
            line_cnt <= '0;
          end else begin
            line_cnt <= line_cnt + 5'd1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign dma_req = (state == FETCH);

  a_line_cnt_range : assert property (
    @(posedge clk_dot4x) !sys_rst |-> line_cnt <= HEIGHT
  );

endmodule : sprite_y_match

/* sprite_dma_arbiter.sv */
`timescale 1ns/1ps

module sprite_dma_arbiter
  import vicii_pkg::*;
(
  input  sprite_mask_t dma_req,
  output sprite_mask_t sprite_dma,
  output logic         ba,
  output sprite_idx_t  dma_index
);

  // per-sprite fetch flags go out as they are
  assign sprite_dma = dma_req;

  // bus available drops while any sprite fetches
  // active low towards the cpu, high when the bus is free
  assign ba = ~|dma_req;

  // priority encoder
  // scanned high to low so the lowest set bit wins
  // 0 when nothing is requested
  always_comb begin
    dma_index = '0;
    for (int n = NUM_SPRITES - 1; n >= 0; n--) begin
      if (dma_req[n]) begin
        dma_index = sprite_idx_t'(n);
      end
    end
  end

endmodule : sprite_dma_arbiter

/* vicii_timing_top.sv */
`timescale 1ns/1ps

module vicii_timing_top
  import vicii_pkg::*;
#(
  parameter chip_t CHIP       = CHIP_6567R8,
  parameter int    RESET_HOLD = 16
) (
  input  logic         clk_dot4x,
  input  logic         rst,
  input  logic         reg_we,
  input  reg_addr_t    reg_addr,
  input  reg_data_t    reg_wdata,
  output logic         phi0,
  output xcycle_t      xcycle,
  output raster_t      raster_line,
  output sprite_mask_t sprite_dma,
  output logic         ba,
  output sprite_idx_t  dma_index
);

  logic                     sys_rst;
  logic                     cycle_ce;
  logic                     check_ce;
  logic [NUM_SPRITES*8-1:0] sprite_y_flat;
  sprite_mask_t             sprite_en;
  sprite_mask_t             dma_req;

  // strobes and stretched reset
  // no pixel pipeline here, so the dot strobe is left open
  vic_clockgen #(
    .RESET_HOLD(RESET_HOLD)
  ) u_clockgen (
    .clk_dot4x(clk_dot4x),
    .rst      (rst),
    .sys_rst  (sys_rst),
    .dot_ce   (),
    .cycle_ce (cycle_ce),
    .phi0     (phi0)
  );

  raster_counter #(
    .CHIP(CHIP)
  ) u_raster (
    .clk_dot4x  (clk_dot4x),
    .sys_rst    (sys_rst),
    .cycle_ce   (cycle_ce),
    .xcycle     (xcycle),
    .raster_line(raster_line),
    .check_ce   (check_ce)
  );

  sprite_regs u_regs (
    .clk_dot4x    (clk_dot4x),
    .sys_rst      (sys_rst),
    .reg_we       (reg_we),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .sprite_y_flat(sprite_y_flat),
    .sprite_en    (sprite_en)
  );

  // one match unit per sprite, compared against the low 8 bits of the line
  for (genvar n = 0; n < NUM_SPRITES; n++) begin : g_sprite
    sprite_y_match u_match (
      .clk_dot4x (clk_dot4x),
      .sys_rst   (sys_rst),
      .check_ce  (check_ce),
      .raster_low(raster_line[7:0]),
      .sprite_y  (sprite_y_flat[n*8 +: 8]),
      .enable    (sprite_en[n]),
      .dma_req   (dma_req[n])
    );
  end

  sprite_dma_arbiter u_arbiter (
    .dma_req   (dma_req),
    .sprite_dma(sprite_dma),
    .ba        (ba),
    .dma_index (dma_index)
  );

endmodule : vicii_timing_top

/* tb_vicii_timing.sv */
`timescale 1ns/1ps

module tb_vicii_timing
  import vicii_pkg::*;
();

  // ntsc 6567R8 geometry, 65 cycles per line
  localparam xcycle_t LAST_CYCLE   = 7'd64;
  localparam int      CYCLE_CLOCKS = 4 * DOTS_PER_CYCLE;
  localparam int      PHI_HALF     = CYCLE_CLOCKS / 2;

  // one full ntsc frame is 263 * 65 * 32 clocks
  localparam int WAIT_LIMIT = 600000;
  localparam int STEP_LIMIT = 2 * CYCLE_CLOCKS;
  localparam int GEOM_LIMIT = 3000;

  logic         clk_dot4x;
  logic         rst;
  logic         reg_we;
  reg_addr_t    reg_addr;
  reg_data_t    reg_wdata;
  logic         phi0;
  xcycle_t      xcycle;
  raster_t      raster_line;
  sprite_mask_t sprite_dma;
  logic         ba;
  sprite_idx_t  dma_index;

  int fd;

  vicii_timing_top #(
    .CHIP      (CHIP_6567R8),
    .RESET_HOLD(16)
  ) DUT (
    .clk_dot4x  (clk_dot4x),
    .rst        (rst),
    .reg_we     (reg_we),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .phi0       (phi0),
    .xcycle     (xcycle),
    .raster_line(raster_line),
    .sprite_dma (sprite_dma),
    .ba         (ba),
    .dma_index  (dma_index)
  );

  // 100 ns clock period
  always #50 clk_dot4x = ~clk_dot4x;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string field, input int expected, input int actual);
    assert (actual == expected) else
      fail_now($sformatf("Mismatch at time %0t: %s expected 0x%0h, got 0x%0h",
                         $time, field, expected, actual));
  endtask

  // one clock write strobe, ends on a falling edge so outputs are settled
  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(posedge clk_dot4x);
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk_dot4x);
    reg_we    <= 1'b0;
    @(negedge clk_dot4x);
  endtask

  task automatic wait_position(input raster_t line, input xcycle_t cyc);
    int  cnt;
    logic found;
    cnt   = 0;
    found = 1'b0;
    while (!found) begin
      @(negedge clk_dot4x);
      cnt++;
      if (raster_line == line && xcycle == cyc) begin
        found = 1'b1;
      end else if (cnt >= WAIT_LIMIT) begin
        fail_now($sformatf("Timeout waiting for raster line %0d cycle %0d", line, cyc));
      end
    end
  endtask

  // the very next cycle step has to land on the given position
  task automatic expect_next_position(input raster_t line, input xcycle_t cyc);
    xcycle_t start_x;
    int      cnt;
    start_x = xcycle;
    cnt     = 0;
    while (xcycle == start_x) begin
      @(negedge clk_dot4x);
      cnt++;
      if (xcycle == start_x && cnt >= STEP_LIMIT) begin
        fail_now("Timeout waiting for the next cpu cycle step");
      end
    end
    check_value("raster_line", int'(line), int'(raster_line));
    check_value("xcycle", int'(cyc), int'(xcycle));
  endtask

  task automatic expect_outputs(input sprite_mask_t mask, input logic exp_ba,
                                input sprite_idx_t idx);
    check_value("sprite_dma", int'(mask), int'(sprite_dma));
    check_value("ba", int'(exp_ba), int'(ba));
    check_value("dma_index", int'(idx), int'(dma_index));
  endtask

  // steps through line 0 into line 1, checking each cycle and the phi0 halves
  task automatic check_line_geometry();
    xcycle_t prev_x;
    xcycle_t next_x;
    raster_t prev_line;
    logic    prev_phi;
    logic    phi_seen;
    logic    done;
    int      clks;
    int      step_clks;
    int      phi_clks;
    clks = 0;
    // anchor on the first step out of cycle 0
    while (xcycle != 7'd1) begin
      @(negedge clk_dot4x);
      clks++;
      if (xcycle != 7'd1 && clks >= GEOM_LIMIT) begin
        fail_now("Timeout waiting for the first cpu cycle after reset");
      end
    end
    prev_x    = xcycle;
    // first line after reset
    prev_line = '0;
    prev_phi  = phi0;
    phi_seen  = 1'b0;
    done      = 1'b0;
    clks      = 0;
    step_clks = 0;
    phi_clks  = 0;
    while (!done) begin
      @(negedge clk_dot4x);
      clks++;
      step_clks++;
      phi_clks++;
      if (clks >= GEOM_LIMIT) begin
        fail_now("Timeout while stepping through a raster line");
      end
      // first toggle only sets the reference point
      if (phi0 != prev_phi) begin
        if (phi_seen) begin
          check_value("phi0 half period", PHI_HALF, phi_clks);
        end
        phi_seen = 1'b1;
        phi_clks = 0;
        prev_phi = phi0;
      end
      if (xcycle != prev_x) begin
        next_x = (prev_x == LAST_CYCLE) ? 7'd0 : prev_x + 7'd1;
        check_value("xcycle", int'(next_x), int'(xcycle));
        check_value("cycle length", CYCLE_CLOCKS, step_clks);
        // a new cycle opens with the low half of phi0
        check_value("phi0", 0, int'(phi0));
        if (prev_x == LAST_CYCLE) begin
          check_value("raster_line", int'(prev_line) + 1, int'(raster_line));
          done = 1'b1;
        end else begin
          check_value("raster_line", int'(prev_line), int'(raster_line));
        end
        prev_x    = xcycle;
        prev_line = raster_line;
        step_clks = 0;
      end
    end
  endtask

  // drops the rest of a comment line
  task automatic skip_line();
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  initial begin
    logic [7:0]   cmd;
    int           n_items;
    logic         eof_seen;
    reg_addr_t    w_addr;
    reg_data_t    w_data;
    raster_t      p_line;
    xcycle_t      p_cyc;
    sprite_mask_t e_mask;
    logic         e_ba;
    sprite_idx_t  e_idx;

    clk_dot4x = 1'b0;
    rst       = 1'b1;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;

    repeat (2) @(posedge clk_dot4x);
    rst <= 1'b0;
    @(negedge clk_dot4x);

    // counters and outputs while the stretched reset runs
    check_value("raster_line", 0, int'(raster_line));
    check_value("xcycle", 0, int'(xcycle));
    expect_outputs(8'h00, 1'b1, 3'd0);

    check_line_geometry();

    fd = $fopen("vicii_timing_patterns.txt", "r");
    if (fd == 0) begin
      fail_now("Could not open the pattern file vicii_timing_patterns.txt");
    end

    eof_seen = 1'b0;
    while (!eof_seen) begin
      n_items = $fscanf(fd, "%s", cmd);
      if (n_items != 1) begin
        eof_seen = 1'b1;
      end else begin
        case (cmd)
          "#": skip_line();
          "w": begin
            n_items = $fscanf(fd, "%h %h", w_addr, w_data);
            if (n_items != 2) fail_now("Malformed write command in the pattern file");
            write_reg(w_addr, w_data);
          end
          "t": begin
            n_items = $fscanf(fd, "%d %d", p_line, p_cyc);
            if (n_items != 2) fail_now("Malformed wait command in the pattern file");
            wait_position(p_line, p_cyc);
          end
          "n": begin
            n_items = $fscanf(fd, "%d %d", p_line, p_cyc);
            if (n_items != 2) fail_now("Malformed step command in the pattern file");
            expect_next_position(p_line, p_cyc);
          end
          "e": begin
            n_items = $fscanf(fd, "%h %d %d", e_mask, e_ba, e_idx);
            if (n_items != 3) fail_now("Malformed expect command in the pattern file");
            expect_outputs(e_mask, e_ba, e_idx);
          end
          default: fail_now("Unknown command in the pattern file");
        endcase
      end
    end
    $fclose(fd);

    $display("Verification passed");
    $finish;
  end

endmodule : tb_vicii_timing

/* vicii_timing_patterns.txt */
# w addr data : register write, both hex
# t line cycle : wait for raster position, decimal
# n line cycle : next cycle step lands here, decimal
# e dma ba idx : expect sprite_dma (hex), ba and dma_index (decimal)
# sprite 0 enabled at Y 10, sprite 1 same Y but disabled
w 01 0a
w 03 0a
w 15 01
t 10 54
e 00 1 0
t 10 56
e 01 0 0
t 30 56
e 01 0 0
t 31 56
e 00 1 0
# sprites 3 and 5 share Y 40
w 07 28
w 0b 28
w 15 28
t 40 56
e 28 0 3
t 60 56
e 28 0 3
t 61 56
e 00 1 0
# sprite 2 matches line 80 but is not enabled
w 05 50
t 80 56
e 00 1 0
t 90 56
e 00 1 0
# line 258 has low byte 2, arm sprite 2 only after it
t 259 0
w 05 02
w 15 04
t 262 64
e 00 1 0
n 0 0
t 2 54
e 00 1 0
t 2 56
e 04 0 2
t 22 56
e 04 0 2
t 23 56
e 00 1 0

/* vicii_timing_top.f */
vicii_pkg.sv
vic_clockgen.sv
raster_counter.sv
sprite_regs.sv
sprite_y_match.sv
sprite_dma_arbiter.sv
vicii_timing_top.sv
tb_vicii_timing.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the vicii timing testbench with verilator
# non-zero exit when the build fails or the log holds the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vicii_timing_top.f --top-module tb_vicii_timing -o tb_vicii_timing
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_vicii_timing > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

exit 0
